//--- hw/vu_pkg.sv
`default_nettype none

package vu_pkg;

  //////////////////////////////////////////////////////////////////////
  // audio side
  //////////////////////////////////////////////////////////////////////

  // decimated mic sample, two's complement
  typedef logic signed [11:0] sample_t;

  // magnitude of a sample
  typedef logic [11:0] mag_t;

  // bar height in rows
  typedef logic [3:0] level_t;

  // top of the bar
  localparam level_t LEVEL_MAX = 4'd10;

  //////////////////////////////////////////////////////////////////////
  // frame bus, single transfer
  //////////////////////////////////////////////////////////////////////

  typedef logic [15:0] bus_adr_t;
  typedef logic [7:0]  bus_dat_t;

  // master to slave, 27 bits
  typedef struct packed {
    bus_adr_t adr;
    bus_dat_t dat;
    logic     we;
    logic     stb;
    logic     cyc;
  } bus_req_t;

  // slave to master, 9 bits
  typedef struct packed {
    bus_dat_t dat;
    logic     ack;
  } bus_rsp_t;

  // row pixel patterns
  localparam bus_dat_t ROW_LIT  = 8'hff;
  localparam bus_dat_t ROW_DARK = 8'h00;

endpackage

`default_nettype wire

//--- hw/level_meter.sv
`timescale 1ns/1ps
`default_nettype none

module level_meter #(
  parameter int UPDATE_COUNT = 60000
) (
  input  wire              clk,
  input  wire              reset_i,
  input  wire vu_pkg::sample_t sample_i,
  input  wire              sample_valid_i,
  output vu_pkg::level_t   level_o
);

  import vu_pkg::*;

  localparam int CNT_W = (UPDATE_COUNT > 1) ? $clog2(UPDATE_COUNT) : 1;

  //////////////////////////////////////////////////////////////////////
  // magnitude and peak tracking
  //////////////////////////////////////////////////////////////////////

  logic [CNT_W-1:0] win_cnt;
  logic             win_end;
  mag_t             cur_mag;
  mag_t             peak;
  mag_t             peak_next;

  // -2048 has no positive twin, clip it
  always_comb begin
    if (sample_i == 12'sh800) begin
      cur_mag = 12'd2047;
    end else if (sample_i[11]) begin
      cur_mag = mag_t'(-sample_i);
    end else begin
      cur_mag = mag_t'(sample_i);
    end
  end

  // peak including this cycle's sample
  assign peak_next = (sample_valid_i && (cur_mag > peak)) ? cur_mag : peak;

  // last cycle of the window
  assign win_end = (win_cnt == '0);

  // priority on highest set bit
  function automatic level_t map_level(input mag_t m);
    level_t lvl;
    if (m[11] || m[10]) lvl = LEVEL_MAX;
    else if (m[9])      lvl = 4'd8;
    else if (m[8])      lvl = 4'd6;
    else if (m[7])      lvl = 4'd4;
    else if (m[6])      lvl = 4'd3;
    else if (m[5])      lvl = 4'd2;
    else if (m[4])      lvl = 4'd1;
    else                lvl = 4'd0;
    return lvl;
  endfunction

  always_ff @(posedge clk) begin
    if (reset_i) begin
      win_cnt <= CNT_W'(UPDATE_COUNT - 1);
      peak    <= '0;
      level_o <= '0;
    end else if (win_end) begin
      // publish held peak, then start fresh
      win_cnt <= CNT_W'(UPDATE_COUNT - 1);
      level_o <= map_level(peak_next);
      peak    <= '0;
    end else begin
      win_cnt <= win_cnt - 1'b1;
      peak    <= peak_next;
    end
  end

  // bar writer relies on this bound
  a_level_range : assert property (
    @(posedge clk) disable iff (reset_i) level_o <= LEVEL_MAX
  );

endmodule

`default_nettype wire

//--- hw/bar_writer.sv
`timescale 1ns/1ps
`default_nettype none

module bar_writer #(
  parameter vu_pkg::bus_adr_t FRAME_BASE = 16'h0400,
  parameter int               NUM_ROWS   = 10
) (
  input  wire                 clk,
  input  wire                 reset_i,
  input  wire vu_pkg::level_t level_i,
  output vu_pkg::bus_req_t    req_o,
  input  wire                 ack_i
);

  import vu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_GAP
  } state_t;

  state_t     state;
  logic [3:0] row;
  level_t     wr_level;
  logic       wr_known;
  logic       last_row;

  assign last_row = (row == 4'(NUM_ROWS - 1));

  //////////////////////////////////////////////////////////////////////
  // pass sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state    <= ST_IDLE;
      row      <= '0;
      wr_level <= '0;
      // nothing in the frame yet
      wr_known <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // new level starts a full pass from row 0
          if (!wr_known || (level_i != wr_level)) begin
            wr_level <= level_i;
            wr_known <= 1'b1;
            row      <= '0;
            state    <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (ack_i) begin
            if (last_row) begin
              state <= ST_IDLE;
            end else begin
              row   <= row + 1'b1;
              state <= ST_GAP;
            end
          end
        end
        // cyc low for one cycle, reader may slip in here
        ST_GAP: state <= ST_REQ;
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request, straight from registered state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    req_o.adr = FRAME_BASE + bus_adr_t'(row);
    // rows below the level are lit
    req_o.dat = (row < wr_level) ? ROW_LIT : ROW_DARK;
    req_o.we  = 1'b1;
    req_o.stb = (state == ST_REQ);
    req_o.cyc = (state == ST_REQ);
  end

  // held until the slave answers
  a_req_stable : assert property (
    @(posedge clk) disable iff (reset_i)
    (req_o.stb && !ack_i) |=> $stable(req_o)
  );

endmodule

`default_nettype wire

//--- hw/scan_reader.sv
`timescale 1ns/1ps
`default_nettype none

module scan_reader #(
  parameter vu_pkg::bus_adr_t FRAME_BASE = 16'h0400,
  parameter int               NUM_ROWS   = 10
) (
  input  wire                   clk,
  input  wire                   reset_i,
  output vu_pkg::bus_req_t      req_o,
  input  wire vu_pkg::bus_rsp_t rsp_i,
  output vu_pkg::bus_dat_t      row_dat_o,
  output logic [3:0]            row_idx_o,
  output logic                  row_valid_o,
  output logic                  frame_done_o
);

  import vu_pkg::*;

  typedef enum logic {
    ST_GAP,
    ST_REQ
  } state_t;

  state_t     state;
  logic [3:0] row;

  //////////////////////////////////////////////////////////////////////
  // row sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= ST_GAP;
      row   <= '0;
    end else begin
      case (state)
        // bus released for a cycle between rows
        ST_GAP: state <= ST_REQ;
        ST_REQ: begin
          if (rsp_i.ack) begin
            state <= ST_GAP;
            // wrap after the last row
            if (row == 4'(NUM_ROWS - 1)) begin
              row <= '0;
            end else begin
              row <= row + 1'b1;
            end
          end
        end
        default: state <= ST_GAP;
      endcase
    end
  end

  // read only, data field unused by the slave
  always_comb begin
    req_o.adr = FRAME_BASE + bus_adr_t'(row);
    req_o.dat = '0;
    req_o.we  = 1'b0;
    req_o.stb = (state == ST_REQ);
    req_o.cyc = (state == ST_REQ);
  end

  //////////////////////////////////////////////////////////////////////
  // row strobes
  //////////////////////////////////////////////////////////////////////

  // payload latched on ack
  always_ff @(posedge clk) begin
    if (rsp_i.ack) begin
      row_dat_o <= rsp_i.dat;
      row_idx_o <= row;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      row_valid_o  <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      row_valid_o  <= (state == ST_REQ) && rsp_i.ack;
      // one cycle behind the last row's pulse
      frame_done_o <= row_valid_o && (row_idx_o == 4'(NUM_ROWS - 1));
    end
  end

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire                   clk,
  input  wire                   reset_i,
  input  wire vu_pkg::bus_req_t wr_req_i,
  input  wire vu_pkg::bus_req_t rd_req_i,
  output logic                  wr_ack_o,
  output vu_pkg::bus_rsp_t      rd_rsp_o,
  output vu_pkg::bus_req_t      mem_req_o,
  input  wire vu_pkg::bus_rsp_t mem_rsp_i
);

  import vu_pkg::*;

  typedef enum logic [1:0] {
    GNT_IDLE,
    GNT_WR,
    GNT_RD
  } gnt_t;

  gnt_t gnt_q;
  gnt_t gnt_d;

  //////////////////////////////////////////////////////////////////////
  // grant with lock
  //////////////////////////////////////////////////////////////////////

  // owner keeps the bus while its cyc is high
  always_comb begin
    case (gnt_q)
      GNT_WR:  gnt_d = wr_req_i.cyc ? GNT_WR : (rd_req_i.cyc ? GNT_RD : GNT_IDLE);
      GNT_RD:  gnt_d = rd_req_i.cyc ? GNT_RD : (wr_req_i.cyc ? GNT_WR : GNT_IDLE);
      // idle bus, writer first
      default: gnt_d = wr_req_i.cyc ? GNT_WR : (rd_req_i.cyc ? GNT_RD : GNT_IDLE);
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      gnt_q <= GNT_IDLE;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  // blocked master is not forwarded
  always_comb begin
    case (gnt_d)
      GNT_WR:  mem_req_o = wr_req_i;
      GNT_RD:  mem_req_o = rd_req_i;
      default: mem_req_o = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // response routing
  //////////////////////////////////////////////////////////////////////

  // ack follows the owner of the transfer
  assign wr_ack_o     = mem_rsp_i.ack && (gnt_q == GNT_WR);
  assign rd_rsp_o.ack = mem_rsp_i.ack && (gnt_q == GNT_RD);
  // data goes everywhere, only the acked one looks
  assign rd_rsp_o.dat = mem_rsp_i.dat;

  a_one_ack : assert property (
    @(posedge clk) disable iff (reset_i) !(wr_ack_o && rd_rsp_o.ack)
  );

  // ack only lands on a master that asked for it and still holds its cycle
  a_wr_ack_owner : assert property (
    @(posedge clk) disable iff (reset_i)
    wr_ack_o |-> (wr_req_i.cyc && $past(wr_req_i.stb))
  );

  a_rd_ack_owner : assert property (
    @(posedge clk) disable iff (reset_i)
    rd_rsp_o.ack |-> (rd_req_i.cyc && $past(rd_req_i.stb))
  );

endmodule

`default_nettype wire

//--- hw/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ram #(
  parameter vu_pkg::bus_adr_t FRAME_BASE = 16'h0400
) (
  input  wire                   clk,
  input  wire                   reset_i,
  input  wire vu_pkg::bus_req_t req_i,
  output vu_pkg::bus_rsp_t      rsp_o
);

  import vu_pkg::*;

  bus_dat_t mem [16];
  bus_dat_t rd_dat;
  logic     ack_q;
  logic     hit;

  // 16 byte window at the frame base
  assign hit = (req_i.adr[15:4] == FRAME_BASE[15:4]);

  // one ack per request, never back to back
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i.cyc && req_i.stb && hit && !ack_q;
    end
  end

  // store on ack, request still held by the master
  always_ff @(posedge clk) begin
    if (ack_q && req_i.we && hit) begin
      mem[req_i.adr[3:0]] <= req_i.dat;
    end
    rd_dat <= mem[req_i.adr[3:0]];
  end

  assign rsp_o.dat = rd_dat;
  assign rsp_o.ack = ack_q;

  a_ack_after_stb : assert property (
    @(posedge clk) disable iff (reset_i) rsp_o.ack |-> $past(req_i.stb)
  );

endmodule

`default_nettype wire

//--- hw/vu_top.sv
`timescale 1ns/1ps
`default_nettype none

module vu_top #(
  parameter int               UPDATE_COUNT = 60000,
  parameter vu_pkg::bus_adr_t FRAME_BASE   = 16'h0400,
  parameter int               NUM_ROWS     = 10
) (
  input  wire                  clk,
  input  wire                  reset_i,
  input  wire vu_pkg::sample_t sample_i,
  input  wire                  sample_valid_i,
  output vu_pkg::level_t       level_o,
  output vu_pkg::bus_dat_t     row_dat_o,
  output logic [3:0]           row_idx_o,
  output logic                 row_valid_o,
  output logic                 frame_done_o
);

  import vu_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // frame bus wiring
  //////////////////////////////////////////////////////////////////////

  bus_req_t wr_req;
  bus_req_t rd_req;
  bus_req_t mem_req;
  bus_rsp_t rd_rsp;
  bus_rsp_t mem_rsp;
  logic     wr_ack;

  // peak meter, drives the bar and the output
  level_meter #(
    .UPDATE_COUNT ( UPDATE_COUNT )
  ) level_meter_i (
    .clk            ( clk            ),
    .reset_i        ( reset_i        ),
    .sample_i       ( sample_i       ),
    .sample_valid_i ( sample_valid_i ),
    .level_o        ( level_o        )
  );

  // writer master, priority on an idle bus
  bar_writer #(
    .FRAME_BASE ( FRAME_BASE ),
    .NUM_ROWS   ( NUM_ROWS   )
  ) bar_writer_i (
    .clk     ( clk     ),
    .reset_i ( reset_i ),
    .level_i ( level_o ),
    .req_o   ( wr_req  ),
    .ack_i   ( wr_ack  )
  );

  // display side, reads without pause
  scan_reader #(
    .FRAME_BASE ( FRAME_BASE ),
    .NUM_ROWS   ( NUM_ROWS   )
  ) scan_reader_i (
    .clk          ( clk          ),
    .reset_i      ( reset_i      ),
    .req_o        ( rd_req       ),
    .rsp_i        ( rd_rsp       ),
    .row_dat_o    ( row_dat_o    ),
    .row_idx_o    ( row_idx_o    ),
    .row_valid_o  ( row_valid_o  ),
    .frame_done_o ( frame_done_o )
  );

  bus_arbiter bus_arbiter_i (
    .clk       ( clk     ),
    .reset_i   ( reset_i ),
    .wr_req_i  ( wr_req  ),
    .rd_req_i  ( rd_req  ),
    .wr_ack_o  ( wr_ack  ),
    .rd_rsp_o  ( rd_rsp  ),
    .mem_req_o ( mem_req ),
    .mem_rsp_i ( mem_rsp )
  );

  frame_ram #(
    .FRAME_BASE ( FRAME_BASE )
  ) frame_ram_i (
    .clk     ( clk     ),
    .reset_i ( reset_i ),
    .req_i   ( mem_req ),
    .rsp_o   ( mem_rsp )
  );

endmodule

`default_nettype wire

//--- test/vu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vu_tb;

  import vu_pkg::*;

  localparam int WINDOW      = 64;
  localparam int HALF        = WINDOW / 2;
  localparam int NUM_ROWS    = 10;
  localparam int NUM_ENTRIES = 10;
  localparam int PIN_POS     = 33;
  localparam int CLK_PERIOD  = 40;
  // four windows per entry covers the drive time plus the trailing frames
  localparam int WATCHDOG_NS = NUM_ENTRIES * 4 * WINDOW * CLK_PERIOD + 20000;

  // one row of the stimulus table
  typedef struct packed {
    logic [11:0] base;
    logic        pin;
    logic        spike_on;
    sample_t     spike;
    logic [5:0]  spike_pos;
    level_t      exp_level;
  } entry_t;

  logic     clk;
  logic     reset_i;
  sample_t  sample_i;
  logic     sample_valid_i;
  level_t   level_o;
  bus_dat_t row_dat_o;
  logic [3:0] row_idx_o;
  logic     row_valid_o;
  logic     frame_done_o;

  entry_t   stim_table [NUM_ENTRIES];
  bus_dat_t frame_rows [NUM_ROWS];
  int       win_peak;
  int       errors;
  int       checks;
  int       tests_run;
  int       frame_checks;
  int       entry_err_start;
  int       row_count;
  int       frame_count;
  int       frame_target;
  int       frame_level;
  logic     frame_pending;

  vu_top #(
    .UPDATE_COUNT ( WINDOW   ),
    .NUM_ROWS     ( NUM_ROWS )
  ) vu_top_i (
    .clk            ( clk            ),
    .reset_i        ( reset_i        ),
    .sample_i       ( sample_i       ),
    .sample_valid_i ( sample_valid_i ),
    .level_o        ( level_o        ),
    .row_dat_o      ( row_dat_o      ),
    .row_idx_o      ( row_idx_o      ),
    .row_valid_o    ( row_valid_o    ),
    .frame_done_o   ( frame_done_o   )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // bar height from peak magnitude, threshold form
  function automatic int level_of(input int mag);
    int lvl;
    if (mag >= 1024)     lvl = 10;
    else if (mag >= 512) lvl = 8;
    else if (mag >= 256) lvl = 6;
    else if (mag >= 128) lvl = 4;
    else if (mag >= 64)  lvl = 3;
    else if (mag >= 32)  lvl = 2;
    else if (mag >= 16)  lvl = 1;
    else                 lvl = 0;
    return lvl;
  endfunction

  function automatic entry_t make_entry(input int base, input bit pin, input bit spike_on,
                                        input int spike, input int pos, input int lvl);
    entry_t ent;
    ent.base      = 12'(base);
    ent.pin       = pin;
    ent.spike_on  = spike_on;
    ent.spike     = sample_t'(spike);
    ent.spike_pos = 6'(pos);
    ent.exp_level = level_t'(lvl);
    return ent;
  endfunction

  task automatic load_table();
    // quiet start, matches the dark frame after reset
    stim_table[0] = make_entry(0,    0, 0, 0,     0,  0);
    stim_table[1] = make_entry(40,   1, 0, 0,     0,  2);
    stim_table[2] = make_entry(300,  1, 0, 0,     0,  6);
    // most negative sample as a lone spike
    stim_table[3] = make_entry(5,    0, 1, -2048, 20, 0);
    stim_table[4] = make_entry(2047, 1, 0, 0,     0,  10);
    stim_table[5] = make_entry(100,  1, 0, 0,     0,  3);
    // spike on the last cycle of the window
    stim_table[6] = make_entry(20,   1, 1, 700,   63, 1);
    stim_table[7] = make_entry(600,  1, 0, 0,     0,  8);
    stim_table[8] = make_entry(130,  1, 1, -1500, 0,  4);
    stim_table[9] = make_entry(0,    0, 0, 0,     0,  0);
  endtask

  // random sign and size, pinned base and spike on top
  task automatic drive_sample(input int e, input int w, input int c);
    int base;
    int s;
    int mag;
    base = int'(stim_table[e].base);
    mag  = $urandom % (base + 1);
    s    = ($urandom & 1) ? -mag : mag;
    if (stim_table[e].pin && (c == PIN_POS)) begin
      s = ($urandom & 1) ? -base : base;
    end
    if (stim_table[e].spike_on && (w == 0) && (c == int'(stim_table[e].spike_pos))) begin
      s = $signed(stim_table[e].spike);
    end
    sample_i       = sample_t'(s);
    sample_valid_i = 1'b1;
    // -2048 clips to 2047
    mag = (s < 0) ? -s : s;
    if (mag > 2047) mag = 2047;
    if (mag > win_peak) win_peak = mag;
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_level(input int expected, input string what);
    checks++;
    if (level_o !== level_t'(expected)) begin
      $display("MISMATCH t=%0t %s level_o: got %0d expected %0d",
               $time, what, level_o, expected);
      errors++;
    end
  endtask

  task automatic close_entry(input int idx, input int final_lvl);
    check_level(final_lvl, $sformatf("entry %0d final", idx));
    // table column must agree with the samples that were driven
    if (final_lvl != int'(stim_table[idx].exp_level)) begin
      $display("entry %0d samples map to level %0d but the table expects %0d",
               idx, final_lvl, stim_table[idx].exp_level);
      errors++;
    end
    tests_run++;
    $display("test %0d base %0d spike %0d: level %0d %s", idx, stim_table[idx].base,
             stim_table[idx].spike_on ? $signed(stim_table[idx].spike) : 0, final_lvl,
             (errors == entry_err_start) ? "pass" : "FAIL");
    entry_err_start = errors;
  endtask

  // compare the frame that ends after the given number of frame_done pulses
  task automatic arm_frame_check(input int lvl, input int frames_ahead);
    if (frame_pending) begin
      $display("frame check for level %0d did not run before the next one was armed",
               frame_level);
      errors++;
    end
    frame_level   = lvl;
    frame_target  = frame_count + frames_ahead;
    frame_pending = 1'b1;
  endtask

  task automatic compare_frame();
    int       bad;
    bus_dat_t want;
    bad = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      // rows below the level lit
      want = (r < frame_level) ? ROW_LIT : ROW_DARK;
      if (frame_rows[r] !== want) begin
        $display("MISMATCH t=%0t row_dat_o row %0d: got %02h expected %02h",
                 $time, r, frame_rows[r], want);
        bad++;
      end
    end
    errors += bad;
    frame_checks++;
    frame_pending = 1'b0;
    $display("frame check level %0d: %s", frame_level, (bad == 0) ? "pass" : "FAIL");
  endtask

  // row strobes, sampled before the edge updates them
  always @(posedge clk) begin
    if (reset_i) begin
      row_count   = 0;
      frame_count = 0;
    end else begin
      if (row_valid_o) begin
        if (row_idx_o != 4'(row_count)) begin
          $display("MISMATCH t=%0t row_idx_o: got %0d expected %0d",
                   $time, row_idx_o, row_count);
          errors++;
        end
        if (row_count < NUM_ROWS) frame_rows[row_count] = row_dat_o;
        row_count++;
      end
      if (frame_done_o) begin
        if (row_count != NUM_ROWS) begin
          $display("frame ended after %0d row strobes instead of %0d at t=%0t",
                   row_count, NUM_ROWS, $time);
          errors++;
        end
        frame_count++;
        if (frame_pending && (frame_count == frame_target)) compare_frame();
        row_count = 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int lvl_win [3];
    int prev_final;
    clk             = 1'b0;
    reset_i         = 1'b1;
    sample_i        = '0;
    sample_valid_i  = 1'b0;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    frame_checks    = 0;
    entry_err_start = 0;
    frame_pending   = 1'b0;
    prev_final      = 0;
    void'($urandom(32'ha8fa));
    load_table();
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_level(0, "after reset");
    // first full frame after reset is all dark
    arm_frame_check(0, 2);
    @(posedge clk);
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      for (int w = 0; w < 3; w++) begin
        win_peak = 0;
        for (int c = 0; c < WINDOW; c++) begin
          @(negedge clk);
          // released on the first sample so windows line up
          reset_i = 1'b0;
          drive_sample(e, w, c);
          if ((w == 2) && (c == 0)) arm_frame_check(lvl_win[1], 3);
          if (c == HALF) begin
            if (w > 0) check_level(lvl_win[w-1], $sformatf("entry %0d window %0d", e, w - 1));
            else if (e > 0) close_entry(e - 1, prev_final);
          end
        end
        lvl_win[w] = level_of(win_peak);
      end
      prev_final = lvl_win[2];
    end
    // quiet tail up to the middle of the next window
    for (int c = 0; c <= HALF; c++) begin
      @(negedge clk);
      sample_i = '0;
    end
    close_entry(NUM_ENTRIES - 1, prev_final);
    wait (frame_pending == 1'b0);
    $display("%0d tests, %0d frame checks, %0d level checks, %0d errors",
             tests_run, frame_checks, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the run did not reach its end", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hw/vu_pkg.sv
hw/level_meter.sv
hw/bar_writer.sv
hw/scan_reader.sv
hw/bus_arbiter.sv
hw/frame_ram.sv
hw/vu_top.sv
test/vu_tb.sv

//--- Bender.yml
package:
  name: vu_meter

sources:
  - files:
      - hw/vu_pkg.sv
      - hw/level_meter.sv
      - hw/bar_writer.sv
      - hw/scan_reader.sv
      - hw/bus_arbiter.sv
      - hw/frame_ram.sv
      - hw/vu_top.sv
  - target: test
    files:
      - test/vu_tb.sv
